/* logic/dcache_hit_stage.sv */
// Second cache stage doing the tag check, word extract, store merge and victim build, with registered outputs
`timescale 1ns/1ns
`default_nettype none

module dcache_hit_stage (
    input  wire logic                    clk,
    input  wire logic                    n_rst,
    input  wire dcache_pkg::dc_req_t     i_req,
    input  wire dcache_pkg::dc_addr_t    i_addr,
    input  wire dcache_pkg::dc_line_rd_t i_line,
    output dcache_pkg::dc_line_wr_t      o_wr,
    output dcache_pkg::dc_rsp_t          o_rsp
);

    logic                                           bypass;
    logic                                           bypass_hit;
    logic [dcache_pkg::DC_TAG_WIDTH-1:0]            eff_tag;
    logic                                           eff_valid;
    logic                                           eff_dirty;
    logic [dcache_pkg::DC_LINE_WIDTH-1:0]           eff_data;
    logic                                           cache_hit;

    logic [dcache_pkg::DC_OFFSET_WIDTH+2:0]         bit_shift;
    logic [dcache_pkg::DC_LINE_WIDTH+dcache_pkg::DC_DATA_WIDTH-1:0] line_shifted;
    logic [dcache_pkg::DC_LINE_WIDTH+dcache_pkg::DC_DATA_WIDTH-1:0] st_data_ext;
    logic [dcache_pkg::DC_LINE_SIZE+dcache_pkg::DC_DATA_SIZE-1:0]   st_mask_ext;
    logic [dcache_pkg::DC_DATA_WIDTH-1:0]           rd_data;
    logic [dcache_pkg::DC_LINE_WIDTH-1:0]           merged_data;
    logic [dcache_pkg::DC_ADDR_WIDTH-1:0]           victim_addr;
    logic                                           wr_en_next;

    dcache_pkg::dc_line_wr_t                        wr_q;
    dcache_pkg::dc_rsp_t                            rsp_q;
    logic                                           wr_en_q;
    logic                                           rsp_valid_q;

    // The array read for this request was issued before the previous write landed,
    // so that write is taken from our own output register instead
    assign bypass     = o_wr.en && (o_wr.index == i_addr.index);
    assign bypass_hit = bypass && (o_wr.tag == i_addr.tag);

    assign eff_tag    = bypass ? o_wr.tag   : i_line.tag;
    assign eff_valid  = bypass ? o_wr.valid : i_line.valid;
    assign eff_dirty  = bypass ? o_wr.dirty : i_line.dirty;
    // Line data only carries over when it is the same line
    assign eff_data   = bypass_hit ? o_wr.data : i_line.data;

    assign cache_hit  = eff_valid && (eff_tag == i_addr.tag);

    assign bit_shift  = {i_addr.offset, 3'b000};

    // Zero bytes above the line make reads past its end come back as zero
    assign line_shifted = {{dcache_pkg::DC_DATA_WIDTH{1'b0}}, eff_data} >> bit_shift;

    always_comb begin
        for (int j = 0; j < dcache_pkg::DC_DATA_SIZE; j++) begin
            rd_data[j*8 +: 8] = i_req.byte_sel[j] ? line_shifted[j*8 +: 8] : 8'h00;
        end
    end

    // Store data and byte mask moved up to the offset, anything above the line is dropped
    assign st_data_ext = {{dcache_pkg::DC_LINE_WIDTH{1'b0}}, i_req.data} << bit_shift;
    assign st_mask_ext = {{dcache_pkg::DC_LINE_SIZE{1'b0}}, i_req.byte_sel} << i_addr.offset;

    always_comb begin
        for (int b = 0; b < dcache_pkg::DC_LINE_SIZE; b++) begin
            merged_data[b*8 +: 8] = st_mask_ext[b] ? st_data_ext[b*8 +: 8] : eff_data[b*8 +: 8];
        end
    end

    assign victim_addr = {eff_tag, i_addr.index, {dcache_pkg::DC_OFFSET_WIDTH{1'b0}}};

    // Fills always write, stores only when they hit
    assign wr_en_next  = i_req.en && (i_req.fill || (i_req.wr_en && cache_hit));

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            wr_en_q     <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            wr_en_q     <= wr_en_next;
            rsp_valid_q <= i_req.en;
        end
    end

    always_ff @(posedge clk) begin
        wr_q.en    <= 1'b0;
        wr_q.index <= i_addr.index;
        wr_q.tag   <= i_addr.tag;
        wr_q.data  <= i_req.fill ? i_req.fill_data : merged_data;
        wr_q.valid <= i_req.valid;
        wr_q.dirty <= i_req.dirty;

        rsp_q.valid        <= 1'b0;
        rsp_q.hit          <= cache_hit;
        rsp_q.data         <= rd_data;
        rsp_q.victim_valid <= eff_valid;
        rsp_q.victim_dirty <= eff_dirty;
        rsp_q.victim_addr  <= victim_addr;
        // Victim data follows the index match alone, the tag need not agree
        rsp_q.victim_data  <= bypass ? o_wr.data : i_line.data;
    end

    always_comb begin
        o_wr        = wr_q;
        o_wr.en     = wr_en_q;
        o_rsp       = rsp_q;
        o_rsp.valid = rsp_valid_q;
    end

    a_fill_writes : assert property (
        @(posedge clk) disable iff (!n_rst)
        (i_req.en && i_req.fill) |=> o_wr.en
    );

    a_wr_has_rsp : assert property (
        @(posedge clk) disable iff (!n_rst)
        o_wr.en |-> o_rsp.valid
    );

endmodule

`default_nettype wire

/* logic/dcache_line_store.sv */
// Tag, state and data arrays of the cache with one registered write-first read port and one write port
`timescale 1ns/1ns
`default_nettype none

module dcache_line_store (
    input  wire logic                                clk,
    input  wire logic                                n_rst,
    input  wire logic [dcache_pkg::DC_INDEX_WIDTH-1:0] i_rd_index,
    input  wire dcache_pkg::dc_line_wr_t             i_wr,
    output dcache_pkg::dc_line_rd_t                  o_rd
);

    logic [dcache_pkg::DC_LINE_COUNT-1:0] valid_q;
    logic [dcache_pkg::DC_LINE_COUNT-1:0] dirty_q;
    logic [dcache_pkg::DC_TAG_WIDTH-1:0]  tag_mem  [dcache_pkg::DC_LINE_COUNT];
    logic [dcache_pkg::DC_LINE_WIDTH-1:0] data_mem [dcache_pkg::DC_LINE_COUNT];

    logic                                 wr_match;
    dcache_pkg::dc_line_rd_t              rd_next;

    // Valid bits are the only state that must come up clean
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
        end else if (i_wr.en) begin
            valid_q[i_wr.index] <= i_wr.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            dirty_q[i_wr.index]  <= i_wr.dirty;
            tag_mem[i_wr.index]  <= i_wr.tag;
            data_mem[i_wr.index] <= i_wr.data;
        end
    end

    // A write to the line being read wins over the old array contents
    assign wr_match = i_wr.en && (i_wr.index == i_rd_index);

    always_comb begin
        if (wr_match) begin
            rd_next.valid = i_wr.valid;
            rd_next.dirty = i_wr.dirty;
            rd_next.tag   = i_wr.tag;
            rd_next.data  = i_wr.data;
        end else begin
            rd_next.valid = valid_q[i_rd_index];
            rd_next.dirty = dirty_q[i_rd_index];
            rd_next.tag   = tag_mem[i_rd_index];
            rd_next.data  = data_mem[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        o_rd <= rd_next;
    end

    // The hit stage must never hand over a line write with an unresolved index
    a_wr_index_known : assert property (
        @(posedge clk) disable iff (!n_rst)
        i_wr.en |-> !$isunknown(i_wr.index)
    );

endmodule

`default_nettype wire

/* logic/dcache_lookup_stage.sv */
// First cache stage that decodes the request address, starts the array read and registers the request
`timescale 1ns/1ns
`default_nettype none

module dcache_lookup_stage (
    input  wire logic                                  clk,
    input  wire logic                                  n_rst,
    input  wire dcache_pkg::dc_req_t                   i_req,
    output logic [dcache_pkg::DC_INDEX_WIDTH-1:0]      o_rd_index,
    output dcache_pkg::dc_req_t                        o_req,
    output dcache_pkg::dc_addr_t                       o_addr
);

    dcache_pkg::dc_addr_t addr_dec;
    dcache_pkg::dc_req_t  req_q;
    logic                 en_q;

    // Tag, index and offset are plain bit fields of the address
    assign addr_dec   = dcache_pkg::dc_addr_t'(i_req.addr);

    // The array read starts in the same cycle the request arrives
    assign o_rd_index = addr_dec.index;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            en_q <= 1'b0;
        end else begin
            en_q <= i_req.en;
        end
    end

    always_ff @(posedge clk) begin
        req_q  <= i_req;
        o_addr <= addr_dec;
    end

    // Only the strobe is trusted after reset, the rest is payload
    always_comb begin
        o_req    = req_q;
        o_req.en = en_q;
    end

endmodule

`default_nettype wire

/* logic/dcache_pkg.sv */
// Shared data cache geometry and the packed request, response and line structs for every block
`default_nettype none

package dcache_pkg;

    // Base geometry of the cache
    localparam int DC_DATA_WIDTH   = 32;
    localparam int DC_ADDR_WIDTH   = 32;
    localparam int DC_CACHE_SIZE   = 256;
    localparam int DC_LINE_SIZE    = 16;

    // Derived widths
    localparam int DC_LINE_WIDTH   = DC_LINE_SIZE * 8;
    localparam int DC_OFFSET_WIDTH = $clog2(DC_LINE_SIZE);
    localparam int DC_INDEX_WIDTH  = $clog2(DC_CACHE_SIZE / DC_LINE_SIZE);
    localparam int DC_TAG_WIDTH    = DC_ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;
    localparam int DC_DATA_SIZE    = DC_DATA_WIDTH / 8;
    localparam int DC_LINE_COUNT   = 2 ** DC_INDEX_WIDTH;

    // A load, a store or a fill, as presented by the load/store path
    typedef struct packed {
        logic                       en;
        logic                       wr_en;
        logic                       fill;
        logic [DC_ADDR_WIDTH-1:0]   addr;
        logic [DC_DATA_SIZE-1:0]    byte_sel;
        logic [DC_DATA_WIDTH-1:0]   data;
        logic [DC_LINE_WIDTH-1:0]   fill_data;
        logic                       valid;
        logic                       dirty;
    } dc_req_t;

    // Address split, most significant field first
    typedef struct packed {
        logic [DC_TAG_WIDTH-1:0]    tag;
        logic [DC_INDEX_WIDTH-1:0]  index;
        logic [DC_OFFSET_WIDTH-1:0] offset;
    } dc_addr_t;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [DC_TAG_WIDTH-1:0]    tag;
        logic [DC_LINE_WIDTH-1:0]   data;
    } dc_line_rd_t;

    typedef struct packed {
        logic                       en;
        logic [DC_INDEX_WIDTH-1:0]  index;
        logic [DC_TAG_WIDTH-1:0]    tag;
        logic [DC_LINE_WIDTH-1:0]   data;
        logic                       valid;
        logic                       dirty;
    } dc_line_wr_t;

    // Victim fields are what the lower level needs to write a line back
    typedef struct packed {
        logic                       valid;
        logic                       hit;
        logic [DC_DATA_WIDTH-1:0]   data;
        logic                       victim_valid;
        logic                       victim_dirty;
        logic [DC_ADDR_WIDTH-1:0]   victim_addr;
        logic [DC_LINE_WIDTH-1:0]   victim_data;
    } dc_rsp_t;

endpackage

`default_nettype wire

/* logic/dcache_top.sv */
// Data cache core top level joining the lookup stage, the line store and the hit stage
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire logic                clk,
    input  wire logic                n_rst,
    input  wire dcache_pkg::dc_req_t i_req,
    output dcache_pkg::dc_rsp_t      o_rsp
);

    logic [dcache_pkg::DC_INDEX_WIDTH-1:0] rd_index;
    dcache_pkg::dc_req_t                   req_s1;
    dcache_pkg::dc_addr_t                  addr_s1;
    dcache_pkg::dc_line_rd_t               line_rd;
    dcache_pkg::dc_line_wr_t               line_wr;

    // Address decode and request register, the array read starts here
    dcache_lookup_stage dcache_lookup_stage_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_req      (i_req),
        .o_rd_index (rd_index),
        .o_req      (req_s1),
        .o_addr     (addr_s1)
    );

    // The read result lines up with the stage-one request
    dcache_line_store dcache_line_store_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_rd_index (rd_index),
        .i_wr       (line_wr),
        .o_rd       (line_rd)
    );

    // Produces the response and the line write that lands one cycle later
    dcache_hit_stage dcache_hit_stage_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_req      (req_s1),
        .i_addr     (addr_s1),
        .i_line     (line_rd),
        .o_wr       (line_wr),
        .o_rsp      (o_rsp)
    );

endmodule

`default_nettype wire

/* tb.f */
logic/dcache_pkg.sv
logic/dcache_line_store.sv
logic/dcache_lookup_stage.sv
logic/dcache_hit_stage.sv
logic/dcache_top.sv
testbench/dcache_tb.sv

/* testbench/dcache_cases.txt */
// Request line: op (0 load, 1 store, 2 fill), group start, addr, byte_sel, data, fill_data, state
// Expected line: hit, data, victim (8 check all, 2 valid, 1 dirty), victim_addr, victim_data
// Cold lines miss
0 1 00001020 0 00000000 0 0
0 00000000 0 0 0
0 0 0000ab54 0 00000000 0 0
0 00000000 0 0 0
// Fill, then loads through the bypass and the write-first read
2 1 00001020 0 00000000 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 2
0 00000000 0 0 0
0 0 00001020 f 00000000 0 0
1 a3a2a1a0 a 00001020 afaeadacabaaa9a8a7a6a5a4a3a2a1a0
0 0 00001027 f 00000000 0 0
1 aaa9a8a7 2 0 0
0 0 0000102d f 00000000 0 0
1 00afaead 2 0 0
0 0 0000102a 5 00000000 0 0
1 00ac00aa 2 0 0
// Partial store hit with dirty set
1 1 00001024 6 11223344 0 3
1 00a6a500 2 0 0
0 0 00001024 f 00000000 0 0
1 a72233a4 b 00001020 afaeadacabaaa9a8a72233a4a3a2a1a0
// Store miss leaves the line alone
1 1 00003324 f deadbeef 0 3
0 a72233a4 b 00001020 afaeadacabaaa9a8a72233a4a3a2a1a0
0 0 00001020 f 00000000 0 0
1 a3a2a1a0 2 0 0
0 0 00003324 f 00000000 0 0
0 a72233a4 2 0 0
// Store near the line end
1 1 0000102e f 55667788 0 3
1 0000afae 2 0 0
0 0 0000102c f 00000000 0 0
1 7788adac b 00001020 7788adacabaaa9a8a72233a4a3a2a1a0
0 0 0000102f f 00000000 0 0
1 00000077 2 0 0
// Fill with a new tag evicts the dirty line
2 1 00003320 0 00000000 3f3e3d3c3b3a39383736353433323130 2
0 00000000 b 00001020 7788adacabaaa9a8a72233a4a3a2a1a0
0 0 00003328 f 00000000 0 0
1 3b3a3938 a 00003320 3f3e3d3c3b3a39383736353433323130
0 0 00001020 f 00000000 0 0
0 33323130 2 0 0
// Second index, clean store and a miss on another tag
2 1 0000ab50 0 00000000 cfcecdcccbcac9c8c7c6c5c4c3c2c1c0 2
0 00000000 0 0 0
0 0 0000ab5d 3 00000000 0 0
1 0000cecd a 0000ab50 cfcecdcccbcac9c8c7c6c5c4c3c2c1c0
1 0 0000ab5c f 01020304 0 2
1 cfcecdcc 2 0 0
0 0 0000ab5c f 00000000 0 0
1 01020304 a 0000ab50 01020304cbcac9c8c7c6c5c4c3c2c1c0
0 0 00001150 f 00000000 0 0
0 c3c2c1c0 a 0000ab50 01020304cbcac9c8c7c6c5c4c3c2c1c0

/* testbench/dcache_tb.sv */
// Self-checking testbench for the data cache core, replays the request cases from the cases file
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 4;
    localparam int LATENCY    = 2;
    localparam int REC_WORDS  = 12;
    localparam int MAX_CASES  = 64;
    localparam int OP_STORE   = 1;
    localparam int OP_FILL    = 2;

    // Expected response with its checking options and the cycle it must show up in
    typedef struct packed {
        dcache_pkg::dc_rsp_t rsp;
        logic                chk_victim;
        logic [31:0]         due;
    } exp_t;

    logic                clk;
    logic                n_rst;
    dcache_pkg::dc_req_t req;
    dcache_pkg::dc_rsp_t rsp;

    logic [dcache_pkg::DC_LINE_WIDTH-1:0] case_mem [MAX_CASES*REC_WORDS];
    exp_t                                 exp_q [$];
    exp_t                                 cur_exp;
    int                                   num_cases;
    int                                   checked;
    int                                   cycle;

    dcache_top dcache_top_i (
        .clk   (clk),
        .n_rst (n_rst),
        .i_req (req),
        .o_rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Edge counter, read by the driver and the monitor before it moves on
    initial cycle = 0;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int idx,
                                   input logic [dcache_pkg::DC_LINE_WIDTH-1:0] got,
                                   input logic [dcache_pkg::DC_LINE_WIDTH-1:0] exp);
        $display("CHECK FAILED %s in case %0d: got %h expected %h", name, idx, got, exp);
        abort_run();
    endtask

    task automatic load_cases();
        for (int k = 0; k < MAX_CASES * REC_WORDS; k++) begin
            case_mem[k] = '1;
        end
        $readmemh("testbench/dcache_cases.txt", case_mem);
        num_cases = 0;
        // Words the file did not reach keep their all-ones fill and end the list
        while (num_cases < MAX_CASES && case_mem[num_cases * REC_WORDS] !== '1) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No cases could be read from testbench/dcache_cases.txt");
            abort_run();
        end
    endtask

    task automatic run_watchdog(input int n);
        longint limit;
        limit = (longint'(n) * 3 + 50) * CLK_PERIOD;
        #(limit);
        $display("Watchdog expired after %0d ns with %0d of %0d cases checked",
                 limit, checked, n);
        abort_run();
    endtask

    function automatic dcache_pkg::dc_req_t case_req(input int i);
        dcache_pkg::dc_req_t r;
        int                  b;
        b           = i * REC_WORDS;
        r           = '0;
        r.en        = 1'b1;
        r.wr_en     = (case_mem[b][3:0] == OP_STORE);
        r.fill      = (case_mem[b][3:0] == OP_FILL);
        r.addr      = case_mem[b+2][dcache_pkg::DC_ADDR_WIDTH-1:0];
        r.byte_sel  = case_mem[b+3][dcache_pkg::DC_DATA_SIZE-1:0];
        r.data      = case_mem[b+4][dcache_pkg::DC_DATA_WIDTH-1:0];
        r.fill_data = case_mem[b+5];
        r.valid     = case_mem[b+6][1];
        r.dirty     = case_mem[b+6][0];
        return r;
    endfunction

    function automatic exp_t case_exp(input int i);
        exp_t e;
        int   b;
        b                  = i * REC_WORDS + 7;
        e                  = '0;
        e.rsp.valid        = 1'b1;
        e.rsp.hit          = case_mem[b][0];
        e.rsp.data         = case_mem[b+1][dcache_pkg::DC_DATA_WIDTH-1:0];
        e.rsp.victim_valid = case_mem[b+2][1];
        e.rsp.victim_dirty = case_mem[b+2][0];
        e.chk_victim       = case_mem[b+2][3];
        e.rsp.victim_addr  = case_mem[b+3][dcache_pkg::DC_ADDR_WIDTH-1:0];
        e.rsp.victim_data  = case_mem[b+4];
        return e;
    endfunction

    task automatic check_rsp(input dcache_pkg::dc_rsp_t got, input dcache_pkg::dc_rsp_t exp,
                             input logic chk_victim, input int idx);
        if (got.hit !== exp.hit)
            report_mismatch("o_rsp.hit", idx, got.hit, exp.hit);
        if (got.data !== exp.data)
            report_mismatch("o_rsp.data", idx, got.data, exp.data);
        if (got.victim_valid !== exp.victim_valid)
            report_mismatch("o_rsp.victim_valid", idx, got.victim_valid, exp.victim_valid);
        // The rest of the victim is only defined once the line has been written
        if (chk_victim) begin
            if (got.victim_dirty !== exp.victim_dirty)
                report_mismatch("o_rsp.victim_dirty", idx, got.victim_dirty, exp.victim_dirty);
            if (got.victim_addr !== exp.victim_addr)
                report_mismatch("o_rsp.victim_addr", idx, got.victim_addr, exp.victim_addr);
            if (got.victim_data !== exp.victim_data)
                report_mismatch("o_rsp.victim_data", idx, got.victim_data, exp.victim_data);
        end
    endtask

    task automatic check_timing(input dcache_pkg::dc_rsp_t got, input int now);
        if (got.valid && exp_q.size() == 0) begin
            $display("A response came out at cycle %0d while no request was outstanding", now);
            abort_run();
        end
        if (exp_q.size() > 0) begin
            if (!got.valid && exp_q[0].due == now) begin
                $display("Response of case %0d is missing %0d cycles after its request",
                         checked, LATENCY);
                abort_run();
            end
            if (got.valid && exp_q[0].due != now) begin
                $display("Response of case %0d came at cycle %0d but was due at cycle %0d",
                         checked, now, exp_q[0].due);
                abort_run();
            end
        end
    endtask

    // Outputs are sampled at the edge, before the DUT registers move
    always @(posedge clk) begin
        if (n_rst) begin
            check_timing(rsp, cycle);
            if (rsp.valid) begin
                cur_exp = exp_q.pop_front();
                check_rsp(rsp, cur_exp.rsp, cur_exp.chk_victim, checked);
                checked <= checked + 1;
            end
        end
    end

    initial begin : drive_cases
        exp_t e;
        int   gap;
        int   seed_ret;
        n_rst    = 1'b0;
        req      = '0;
        checked  = 0;
        load_cases();
        seed_ret = $urandom(32'h6738);
        fork
            run_watchdog(num_cases);
        join_none
        repeat (RST_CYCLES) @(posedge clk);
        n_rst <= 1'b1;
        // Idle cycles after reset, any response here is flagged by the monitor
        repeat (3) @(posedge clk);
        for (int i = 0; i < num_cases; i++) begin
            gap = 0;
            if (case_mem[i * REC_WORDS + 1][0]) begin
                gap = $urandom % 3;
            end
            repeat (gap) begin
                @(posedge clk);
                req <= '0;
            end
            @(posedge clk);
            req <= case_req(i);
            // Valid after the pipeline latency counted from this edge, then seen one edge later
            e     = case_exp(i);
            e.due = cycle + LATENCY + 1;
            exp_q.push_back(e);
        end
        @(posedge clk);
        req <= '0;
        wait (checked == num_cases);
        repeat (2) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
